/* Bender.yml */
package:
  name: lpif_link

dependencies: {}

sources:
  - rtl/lpif_link_pkg.sv
  - rtl/link_auto_sync.sv
  - rtl/lpif_tx_packer.sv
  - rtl/lpif_rx_unpacker.sv
  - rtl/lpif_link_top.sv
  - target: test
    files:
      - tests/lpif_link_tb.sv

/* lpif_link.f */
rtl/lpif_link_pkg.sv
rtl/link_auto_sync.sv
rtl/lpif_tx_packer.sv
rtl/lpif_rx_unpacker.sv
rtl/lpif_link_top.sv
tests/lpif_link_tb.sv

/* rtl/link_auto_sync.sv */
module link_auto_sync (
  input  logic                                clk_wr,
  input  logic                                reset,
  input  logic                                tx_online,
  input  logic                                rx_online,
  input  logic [lpif_link_pkg::MRK_W-1:0]     tx_mrk_userbit,
  input  logic                                tx_stb_userbit,
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_x_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_y_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_z_value,
  output lpif_link_pkg::link_ctrl_t           ctrl,
  output logic                                stb_bit
);

  ////////////////////////////////////////
  // Stage state
  ////////////////////////////////////////

  // Per stage enable, its last sampled value and the done flag
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0] en_d;
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0] seen_q;
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0] done_q;
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0] done_d;

  // Delay per stage and the running down-counters
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0][lpif_link_pkg::DELAY_W-1:0] dly;
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0][lpif_link_pkg::DELAY_W-1:0] cnt_q;
  logic [lpif_link_pkg::AUTO_SYNC_N-1:0][lpif_link_pkg::DELAY_W-1:0] cnt_d;

  // Y for tx online, Z for strobe insert, X for rx online
  assign dly = {delay_x_value, delay_z_value, delay_y_value};

  ////////////////////////////////////////
  // Counter next state
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < lpif_link_pkg::AUTO_SYNC_N; i++) begin
      // Strobe stage chains on the next tx online flag
      case (i)
        lpif_link_pkg::SYNC_TX:  en_d[i] = tx_online;
        lpif_link_pkg::SYNC_STB: en_d[i] = done_d[lpif_link_pkg::SYNC_TX];
        default:                 en_d[i] = rx_online;
      endcase

      cnt_d[i]  = cnt_q[i];
      done_d[i] = done_q[i];

      if (!en_d[i]) begin
        // Input low clears the stage at once
        cnt_d[i]  = '0;
        done_d[i] = 1'b0;
      end else if (!seen_q[i]) begin
        // First edge with input high
        if (dly[i] == '0) begin
          done_d[i] = 1'b1;
        end else begin
          cnt_d[i] = dly[i];
        end
      end else if (!done_q[i]) begin
        // Counting down toward expiry
        if (cnt_q[i] <= 1) begin
          cnt_d[i]  = '0;
          done_d[i] = 1'b1;
        end else begin
          cnt_d[i] = cnt_q[i] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      seen_q <= '0;
      done_q <= '0;
      cnt_q  <= '0;
    end else begin
      seen_q <= en_d;
      done_q <= done_d;
      cnt_q  <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Markers persist for as long as insertion is on
  assign ctrl = '{
    tx_online: done_q[lpif_link_pkg::SYNC_TX],
    ins_stb:   done_q[lpif_link_pkg::SYNC_STB],
    mrk:       done_q[lpif_link_pkg::SYNC_STB] ? tx_mrk_userbit : '0,
    rx_online: done_q[lpif_link_pkg::SYNC_RX]
  };

  // User strobe only once insertion is enabled
  assign stb_bit = tx_stb_userbit & done_q[lpif_link_pkg::SYNC_STB];

  // Losing tx online drops the whole transmit chain next cycle
  a_tx_off_clears: assert property (@(posedge clk_wr) disable iff (reset)
    !tx_online |=> !ctrl.ins_stb && !ctrl.tx_online);

  a_rx_off_clears: assert property (@(posedge clk_wr) disable iff (reset)
    !rx_online |=> !ctrl.rx_online);

endmodule

/* rtl/lpif_link_pkg.sv */
package lpif_link_pkg;

  ////////////////////////////////////////
  // LPIF beat field widths
  ////////////////////////////////////////

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 256;
  localparam int CRC_W    = 8;

  // Whole beat including the three single-bit flags
  localparam int LINK_W = STATE_W + PROTID_W + DATA_W + CRC_W + 3;

  ////////////////////////////////////////
  // PHY channel geometry
  ////////////////////////////////////////

  localparam int PHY_W = 160;
  localparam int MRK_W = 2;

  // Link word padded by one bit, then halved
  localparam int CHAN_PAYLOAD_W = (LINK_W + 1) / 2;

  // Top bits of every PHY word left unused
  localparam int PAD_W = PHY_W - CHAN_PAYLOAD_W - 1 - MRK_W;

  // Config and status widths
  localparam int DELAY_W = 16;
  localparam int DEBUG_W = 32;

  // Auto-sync stage indices
  localparam int SYNC_TX     = 0;
  localparam int SYNC_STB    = 1;
  localparam int SYNC_RX     = 2;
  localparam int AUTO_SYNC_N = 3;

  // One LPIF beat, state in the top bits
  typedef struct packed {
    logic [STATE_W-1:0]  state;
    logic [PROTID_W-1:0] protid;
    logic [DATA_W-1:0]   data;
    logic                dvalid;
    logic [CRC_W-1:0]    crc;
    logic                crc_valid;
    logic                valid;
  } lpif_stream_t;

  // One 160-bit word on a PHY channel
  typedef struct packed {
    logic [PAD_W-1:0]          pad;
    logic [CHAN_PAYLOAD_W-1:0] payload;
    logic                      strobe;
    logic [MRK_W-1:0]          marker;
  } phy_chan_t;

  // Auto-sync outputs toward the datapath
  typedef struct packed {
    logic             tx_online;
    logic             ins_stb;
    logic [MRK_W-1:0] mrk;
    logic             rx_online;
  } link_ctrl_t;

endpackage

/* rtl/lpif_link_top.sv */
module lpif_link_top (
  input  logic                                clk_wr,
  input  logic                                reset,

  // Online control
  input  logic                                tx_online,
  input  logic                                rx_online,

  // User strobe and marker bits
  input  logic [lpif_link_pkg::MRK_W-1:0]     tx_mrk_userbit,
  input  logic                                tx_stb_userbit,

  // Online delays in cycles
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_x_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_y_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_z_value,

  // LPIF streams
  input  lpif_link_pkg::lpif_stream_t         dstrm,
  output lpif_link_pkg::lpif_stream_t         ustrm,

  // PHY lanes
  output lpif_link_pkg::phy_chan_t            tx_phy0,
  output lpif_link_pkg::phy_chan_t            tx_phy1,
  input  lpif_link_pkg::phy_chan_t            rx_phy0,
  input  lpif_link_pkg::phy_chan_t            rx_phy1,

  // Debug status
  output logic [lpif_link_pkg::DEBUG_W-1:0]   tx_downstream_debug_status,
  output logic [lpif_link_pkg::DEBUG_W-1:0]   rx_upstream_debug_status
);

  // Sequenced control to both datapaths
  lpif_link_pkg::link_ctrl_t ctrl;

  // Gated user strobe
  logic stb_bit;

  ////////////////////////////////////////
  // Auto sync
  ////////////////////////////////////////

  link_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .ctrl           (ctrl),
    .stb_bit        (stb_bit)
  );

  ////////////////////////////////////////
  // Datapaths
  ////////////////////////////////////////

  // Downstream toward the PHY
  lpif_tx_packer u_tx_packer (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .ctrl       (ctrl),
    .stb_bit    (stb_bit),
    .dstrm      (dstrm),
    .tx_phy0    (tx_phy0),
    .tx_phy1    (tx_phy1),
    .sent_count (tx_downstream_debug_status)
  );

  // Upstream from the PHY
  lpif_rx_unpacker u_rx_unpacker (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .rx_online  (ctrl.rx_online),
    .rx_phy0    (rx_phy0),
    .rx_phy1    (rx_phy1),
    .ustrm      (ustrm),
    .drop_count (rx_upstream_debug_status)
  );

endmodule

/* rtl/lpif_rx_unpacker.sv */
module lpif_rx_unpacker (
  input  logic                                clk_wr,
  input  logic                                reset,
  input  logic                                rx_online,
  input  lpif_link_pkg::phy_chan_t            rx_phy0,
  input  lpif_link_pkg::phy_chan_t            rx_phy1,
  output lpif_link_pkg::lpif_stream_t         ustrm,
  output logic [lpif_link_pkg::DEBUG_W-1:0]   drop_count
);

  ////////////////////////////////////////
  // Rebuild
  ////////////////////////////////////////

  // Both lanes must carry the strobe
  logic both_stb;

  // Beat rebuilt from the two payloads
  lpif_link_pkg::lpif_stream_t rx_beat;

  // Word is accepted this edge
  logic take;

  // Valid beat that is thrown away
  logic drop;

  assign both_stb = rx_phy0.strobe & rx_phy1.strobe;

  // Spare top bit of channel 1 is not part of the beat
  assign rx_beat = lpif_link_pkg::lpif_stream_t'({
    rx_phy1.payload[lpif_link_pkg::LINK_W-lpif_link_pkg::CHAN_PAYLOAD_W-1:0],
    rx_phy0.payload
  });

  assign take = rx_online & both_stb;

  // Only counted while the receive side is online
  assign drop = rx_online & ~both_stb & rx_beat.valid;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm <= '0;
    end else if (take) begin
      ustrm <= rx_beat;
    end else begin
      // Nothing forwarded without a full strobe pair
      ustrm <= '0;
    end
  end

  // Dropped word counter for debug status
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      drop_count <= '0;
    end else if (drop) begin
      drop_count <= drop_count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Upstream valid traces back to an online receive path
  a_valid_needs_online: assert property (@(posedge clk_wr) disable iff (reset)
    ustrm.valid |-> $past(rx_online));

endmodule

/* rtl/lpif_tx_packer.sv */
module lpif_tx_packer (
  input  logic                                clk_wr,
  input  logic                                reset,
  input  lpif_link_pkg::link_ctrl_t           ctrl,
  input  logic                                stb_bit,
  input  lpif_link_pkg::lpif_stream_t         dstrm,
  output lpif_link_pkg::phy_chan_t            tx_phy0,
  output lpif_link_pkg::phy_chan_t            tx_phy1,
  output logic [lpif_link_pkg::DEBUG_W-1:0]   sent_count
);

  ////////////////////////////////////////
  // Link word split
  ////////////////////////////////////////

  // Beat zero-extended to two full payloads
  logic [2*lpif_link_pkg::CHAN_PAYLOAD_W-1:0] link_ext;

  // Low half to channel 0
  logic [lpif_link_pkg::CHAN_PAYLOAD_W-1:0] pay_lo;

  // High half with the spare zero on top to channel 1
  logic [lpif_link_pkg::CHAN_PAYLOAD_W-1:0] pay_hi;

  assign link_ext = {
    {(2*lpif_link_pkg::CHAN_PAYLOAD_W - lpif_link_pkg::LINK_W){1'b0}},
    dstrm
  };

  assign pay_lo = link_ext[lpif_link_pkg::CHAN_PAYLOAD_W-1:0];
  assign pay_hi = link_ext[2*lpif_link_pkg::CHAN_PAYLOAD_W-1 -: lpif_link_pkg::CHAN_PAYLOAD_W];

  // Builds one PHY word, pad stays zero
  function automatic lpif_link_pkg::phy_chan_t make_chan(
    input logic [lpif_link_pkg::CHAN_PAYLOAD_W-1:0] payload,
    input logic                                     stb,
    input logic [lpif_link_pkg::MRK_W-1:0]          mrk
  );
    lpif_link_pkg::phy_chan_t w;
    w         = '0;
    w.payload = payload;
    w.strobe  = stb;
    w.marker  = mrk;
    return w;
  endfunction

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0    <= '0;
      tx_phy1    <= '0;
      sent_count <= '0;
    end else if (ctrl.tx_online) begin
      // Same strobe and marker stamped on both lanes
      tx_phy0 <= make_chan(pay_lo, stb_bit, ctrl.mrk);
      tx_phy1 <= make_chan(pay_hi, stb_bit, ctrl.mrk);

      // Count only real beats
      if (dstrm.valid) begin
        sent_count <= sent_count + 1'b1;
      end
    end else begin
      // Idle lanes while offline
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_pad_zero: assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0.pad == '0 && tx_phy1.pad == '0);

  // Strobe on the wire only after auto-sync enabled insertion
  a_stb_needs_ins: assert property (@(posedge clk_wr) disable iff (reset)
    (tx_phy0.strobe || tx_phy1.strobe) |-> $past(ctrl.ins_stb));

endmodule

/* tests/lpif_link_tb.sv */
module lpif_link_tb;

  logic                                   clk_wr;
  logic                                   reset;
  logic                                   tx_online;
  logic                                   rx_online;
  logic [lpif_link_pkg::MRK_W-1:0]        tx_mrk_userbit;
  logic                                   tx_stb_userbit;
  logic [lpif_link_pkg::DELAY_W-1:0]      delay_x_value;
  logic [lpif_link_pkg::DELAY_W-1:0]      delay_y_value;
  logic [lpif_link_pkg::DELAY_W-1:0]      delay_z_value;
  lpif_link_pkg::lpif_stream_t            dstrm;
  lpif_link_pkg::lpif_stream_t            ustrm;
  lpif_link_pkg::phy_chan_t               tx_phy0;
  lpif_link_pkg::phy_chan_t               tx_phy1;
  logic [lpif_link_pkg::DEBUG_W-1:0]      tx_dbg;
  logic [lpif_link_pkg::DEBUG_W-1:0]      rx_dbg;

  // Reference model state
  int                                     tx_age;
  int                                     rx_age;
  logic                                   m_tx_on;
  logic                                   m_ins;
  logic                                   m_rx_on;
  lpif_link_pkg::phy_chan_t               exp_tx0;
  lpif_link_pkg::phy_chan_t               exp_tx1;
  lpif_link_pkg::lpif_stream_t            exp_ustrm;
  lpif_link_pkg::lpif_stream_t            pend_beat;
  logic                                   pend_fwd;
  logic                                   pend_valid;
  logic [lpif_link_pkg::DEBUG_W-1:0]      exp_sent;
  logic [lpif_link_pkg::DEBUG_W-1:0]      exp_drop;

  // Bookkeeping
  logic [31:0]                            seed;
  int                                     checks;
  int                                     errors;
  int                                     tests;
  int                                     test_err;

  // TX lanes wired straight back into RX
  lpif_link_top UUT (
    .clk_wr                     (clk_wr),
    .reset                      (reset),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .dstrm                      (dstrm),
    .ustrm                      (ustrm),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (tx_phy0),
    .rx_phy1                    (tx_phy1),
    .tx_downstream_debug_status (tx_dbg),
    .rx_upstream_debug_status   (rx_dbg)
  );

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Stimulus and reference functions
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic lpif_link_pkg::lpif_stream_t rand_beat();
    lpif_link_pkg::lpif_stream_t b;
    for (int i = 0; i < 8; i++) begin
      seed = lcg_next(seed);
      b.data[i*32 +: 32] = seed;
    end
    seed = lcg_next(seed);
    b.state     = seed[31:28];
    b.protid    = seed[27:26];
    b.dvalid    = seed[25];
    b.crc       = seed[24:17];
    b.crc_valid = seed[16];
    b.valid     = seed[15];
    return b;
  endfunction

  // Expected PHY word, beat padded to 274 bits and halved
  function automatic lpif_link_pkg::phy_chan_t expect_phy(
    input lpif_link_pkg::lpif_stream_t     beat,
    input logic                            hi,
    input logic                            on,
    input logic                            ins,
    input logic                            stb,
    input logic [lpif_link_pkg::MRK_W-1:0] mrk
  );
    logic [2*lpif_link_pkg::CHAN_PAYLOAD_W-1:0] ext;
    lpif_link_pkg::phy_chan_t                   w;
    ext = {1'b0, beat};
    w   = '0;
    if (on) begin
      w.payload = hi ? ext[2*lpif_link_pkg::CHAN_PAYLOAD_W-1 -: lpif_link_pkg::CHAN_PAYLOAD_W]
                     : ext[lpif_link_pkg::CHAN_PAYLOAD_W-1:0];
      w.strobe  = stb & ins;
      w.marker  = ins ? mrk : '0;
    end
    return w;
  endfunction

  // Beat comes out only with strobes and an online receiver
  function automatic lpif_link_pkg::lpif_stream_t expect_ustrm(
    input lpif_link_pkg::lpif_stream_t beat,
    input logic                        fwd,
    input logic                        rx_on
  );
    if (fwd && rx_on) begin
      return beat;
    end
    return '0;
  endfunction

  ////////////////////////////////////////
  // Reference timeline and comparison
  ////////////////////////////////////////

  always @(posedge clk_wr) begin
    if (reset) begin
      tx_age     = 0;
      rx_age     = 0;
      m_tx_on    = 1'b0;
      m_ins      = 1'b0;
      m_rx_on    = 1'b0;
      exp_tx0    = '0;
      exp_tx1    = '0;
      exp_ustrm  = '0;
      pend_beat  = '0;
      pend_fwd   = 1'b0;
      pend_valid = 1'b0;
      exp_sent   = '0;
      exp_drop   = '0;
    end else begin
      // Unpacker sees last cycle's words
      exp_ustrm = expect_ustrm(pend_beat, pend_fwd, m_rx_on);
      if (m_rx_on && !pend_fwd && pend_valid) begin
        exp_drop = exp_drop + 1'b1;
      end
      pend_beat  = dstrm;
      pend_fwd   = m_tx_on && m_ins && tx_stb_userbit;
      pend_valid = m_tx_on && dstrm.valid;
      exp_tx0 = expect_phy(dstrm, 1'b0, m_tx_on, m_ins, tx_stb_userbit, tx_mrk_userbit);
      exp_tx1 = expect_phy(dstrm, 1'b1, m_tx_on, m_ins, tx_stb_userbit, tx_mrk_userbit);
      if (m_tx_on && dstrm.valid) begin
        exp_sent = exp_sent + 1'b1;
      end
      // Ages count edges in a row with the input high
      tx_age  = tx_online ? tx_age + 1 : 0;
      rx_age  = rx_online ? rx_age + 1 : 0;
      m_tx_on = tx_age > delay_y_value;
      m_ins   = tx_age > delay_y_value + delay_z_value;
      m_rx_on = rx_age > delay_x_value;
    end
  end

  task automatic check_val(input string name, input logic [272:0] exp_v,
                           input logic [272:0] got_v);
    checks++;
    assert (got_v === exp_v) else begin
      $display("error t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk_wr) begin
    if (!reset) begin
      check_val("tx_phy0", exp_tx0, tx_phy0);
      check_val("tx_phy1", exp_tx1, tx_phy1);
      check_val("ustrm", exp_ustrm, ustrm);
      check_val("tx_downstream_debug_status", exp_sent, tx_dbg);
      check_val("rx_upstream_debug_status", exp_drop, rx_dbg);
    end
  end

  ////////////////////////////////////////
  // Sequencing helpers
  ////////////////////////////////////////

  // One beat per rising edge, returns at the falling edge
  task automatic step(input logic rnd, output logic v);
    lpif_link_pkg::lpif_stream_t b;
    @(posedge clk_wr);
    b = '0;
    if (rnd) begin
      b = rand_beat();
    end
    dstrm <= b;
    v = b.valid;
    @(negedge clk_wr);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  task automatic timed_out(input string what);
    $display("timeout: gave up waiting for %s", what);
    errors++;
  endtask

  initial begin
    logic        v;
    int          n;
    int          first;
    int          stb_at;
    int          win;
    int          nvalid;
    logic [31:0] base;
    logic [63:0] vbits;
    seed           = 32'd19455;
    checks         = 0;
    errors         = 0;
    tests          = 0;
    test_err       = 0;
    reset          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = 2'b10;
    tx_stb_userbit = 1'b1;
    delay_x_value  = 16'd4;
    delay_y_value  = 16'd5;
    delay_z_value  = 16'd3;
    dstrm          = '0;
    vbits          = '0;
    repeat (5) @(posedge clk_wr);
    reset <= 1'b0;

    // Outputs stay quiet with both sides offline
    repeat (10) step(1'b1, v);
    end_test("reset_state");

    // Receiver comes up first so strobe-less words get counted
    @(posedge clk_wr);
    rx_online <= 1'b1;
    @(negedge clk_wr);
    repeat (delay_x_value + 3) step(1'b0, v);
    @(posedge clk_wr);
    tx_online <= 1'b1;
    @(negedge clk_wr);
    n      = 0;
    first  = 0;
    stb_at = 0;
    while (stb_at == 0 && n < 64) begin
      step(1'b1, v);
      vbits[n] = v;
      n++;
      if (first == 0 && tx_phy0 != '0) begin
        first = n;
      end
      if (tx_phy0.strobe && tx_phy1.strobe) begin
        stb_at = n;
      end
    end
    if (stb_at == 0 || first == 0) begin
      timed_out("strobe on both PHY channels");
    end else begin
      // Edge to see the input, the delay, then the packer register
      check_val("first tx word cycle", delay_y_value + 2, first);
      check_val("strobe-less tx words", delay_z_value, stb_at - first);
      check_val("tx_phy0.marker", tx_mrk_userbit, tx_phy0.marker);
      check_val("tx_phy1.marker", tx_mrk_userbit, tx_phy1.marker);
    end
    end_test("online_delays");

    // Beats y+1 to y+z go out online but without a strobe
    win = 0;
    for (int k = delay_y_value; k < delay_y_value + delay_z_value; k++) begin
      win += vbits[k];
    end
    step(1'b1, v);
    step(1'b1, v);
    check_val("rx_upstream_debug_status", win, rx_dbg);
    end_test("strobe_less_drops");

    step(1'b0, v);
    base   = tx_dbg;
    nvalid = 0;
    repeat (200) begin
      step(1'b1, v);
      nvalid += v;
    end
    step(1'b0, v);
    step(1'b0, v);
    check_val("tx_downstream_debug_status", base + nvalid, tx_dbg);
    end_test("loopback_data");

    // Receiver offline while strobes still arrive
    @(posedge clk_wr);
    rx_online <= 1'b0;
    @(negedge clk_wr);
    repeat (4) step(1'b1, v);
    check_val("ustrm", '0, ustrm);

    // Receiver back up, beats return after its own delay
    @(posedge clk_wr);
    rx_online <= 1'b1;
    @(negedge clk_wr);
    n = 0;
    while (ustrm == '0 && n < 64) begin
      step(1'b1, v);
      n++;
    end
    if (n >= 64) begin
      timed_out("ustrm after rx_online high");
    end else begin
      check_val("first ustrm cycle", delay_x_value + 2, n);
    end

    // Strobe off too, so an online receiver would count drops
    @(posedge clk_wr);
    rx_online      <= 1'b0;
    tx_stb_userbit <= 1'b0;
    @(negedge clk_wr);
    step(1'b1, v);
    step(1'b1, v);
    base = rx_dbg;
    repeat (20) step(1'b1, v);
    check_val("rx_upstream_debug_status", base, rx_dbg);
    @(posedge clk_wr);
    tx_online <= 1'b0;
    @(negedge clk_wr);
    n = 0;
    while ((tx_phy0 != '0 || tx_phy1 != '0) && n < 16) begin
      step(1'b1, v);
      n++;
    end
    if (n >= 16) begin
      timed_out("quiet PHY channels after tx_online low");
    end else begin
      check_val("cycles to quiet tx_phy", 2, n);
    end
    end_test("going_offline");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
